// File: project.f
+incdir+include
logic/conv_types_pkg.sv
logic/conv_coeff_pkg.sv
logic/tap_window.sv
logic/channel_mac.sv
logic/output_stage.sv
logic/horizontal_conv_top.sv
sim/tb_horizontal_conv.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_horizontal_conv \
    --Mdir obj_dir \
    -o tb_horizontal_conv > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/tb_horizontal_conv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" sim.log; then
    exit 1
fi

exit 0

// File: sim/conv_patterns.hex
// Columns: act0 act1 act2 (input pixel), expect flag, out0 out1 (expected output).
// Values are 10-bit two's complement, three rows of eight pixels.
// Row 1, small ramp, channel 1 clipped to zero by ReLU.
000 005 000 0 000 000
00a 005 002 0 000 000
014 005 004 1 011 000
01e 005 006 1 01d 000
028 005 008 1 02a 000
032 005 00a 1 036 000
03c 005 00c 1 043 000
046 005 00e 1 04f 000
// Row 2, channel 0 overflows ACT_WIDTH after the shift and wraps.
1ff 000 1ff 0 000 000
1ff 00a 1ff 0 000 000
1ff 014 1ff 1 086 08e
1ff 01e 1ff 1 086 0a2
1ff 028 1ff 1 086 0b6
1ff 032 1ff 1 086 0ca
1ff 03c 1ff 1 086 0de
1ff 046 1ff 1 086 0f2
// Row 3, channel 0 sum is large and negative.
338 000 39c 0 000 000
338 014 39c 0 000 000
338 028 39c 1 000 08c
338 03c 39c 1 000 0b4
338 050 39c 1 000 0dc
338 064 39c 1 000 104
338 078 39c 1 000 12c
338 08c 39c 1 000 154

// File: sim/tb_horizontal_conv.sv
`timescale 1ns/1ps

`include "conv_params.svh"

module tb_horizontal_conv
    import conv_types_pkg::*;
();

    localparam int LINES = 24;
    localparam int WORDS_PER_LINE = 6;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_PASSES = 4;
    localparam int OUTPUTS_PER_PASS = (LINES / `ROW_WIDTH) * (`ROW_WIDTH - `KERNEL_WIDTH + 1);
    localparam int TIMEOUT_CYCLES = NUM_PASSES * 4 * LINES + RESET_CYCLES + 50;

    bit         clock_i;
    bit         reset_i;
    bit         slave_valid_i;
    bit         slave_ready_o;
    in_pixel_t  slave_data_i;
    bit         master_valid_o;
    bit         master_ready_i;
    out_pixel_t master_data_o;

    logic [`ACT_WIDTH-1:0] pattern_mem [0:LINES*WORDS_PER_LINE-1];

    out_pixel_t expected_q [$];
    int         error_count;
    int         output_count;
    int         cycle_count;
    int         tests_passed;
    int         tests_failed;
    bit         stall_mode;
    bit         held_valid;
    out_pixel_t held_data;

    horizontal_conv_top dut_i (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .slave_valid_i (slave_valid_i),
        .slave_ready_o (slave_ready_o),
        .slave_data_i  (slave_data_i),
        .master_valid_o(master_valid_o),
        .master_ready_i(master_ready_i),
        .master_data_o (master_data_o)
    );

    initial begin
        clock_i = 1'b0;
        forever begin
            #50 clock_i = ~clock_i;
        end
    end

    task automatic check_pixel(input out_pixel_t actual, input out_pixel_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_flag(input bit actual, input bit expected, input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s is %0b, expected %0b", $time, what, actual, expected);
            error_count++;
        end
    endtask

    // Consumer side sampled on the rising edge.
    always @(posedge clock_i) begin
        if (reset_i) begin
            if (held_valid) begin
                check_pixel(master_data_o, held_data, "data held during stall");
                check_flag(master_valid_o, 1'b1, "valid held during stall");
            end
            if (!master_ready_i) begin
                check_flag(slave_ready_o, 1'b0, "slave_ready_o while stalled");
            end
            if (master_valid_o && master_ready_i) begin
                output_count++;
                if (expected_q.size() == 0) begin
                    $display("Output taken at %0t with no pixel expected", $time);
                    error_count++;
                end else begin
                    check_pixel(master_data_o, expected_q.pop_front(), "output pixel");
                end
            end
            held_valid = master_valid_o && !master_ready_i;
            held_data = master_data_o;
        end
    end

    // Random back-pressure when enabled.
    initial begin
        forever begin
            @(posedge clock_i);
            #1;
            if (stall_mode) begin
                master_ready_i = ($urandom % 3) != 0;
            end else begin
                master_ready_i = 1'b1;
            end
        end
    end

    always @(posedge clock_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, outputs stopped arriving", cycle_count);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic drive_pixels(input bit gaps);
        in_pixel_t  pixel;
        out_pixel_t expected;
        bit         flag;
        int         base;
        for (int line = 0; line < LINES; line++) begin
            base = line * WORDS_PER_LINE;
            while (gaps && ($urandom % 4) == 0) begin
                slave_valid_i = 1'b0;  // Idle cycle between pixels.
                @(posedge clock_i);
                #1;
            end
            for (int c = 0; c < `CONV_IN_CHANNELS; c++) begin
                pixel[c] = activation_t'(pattern_mem[base + c]);
            end
            flag = pattern_mem[base + 3][0];
            for (int o = 0; o < `CONV_OUT_CHANNELS; o++) begin
                expected[o] = activation_t'(pattern_mem[base + 4 + o]);
            end
            slave_valid_i = 1'b1;
            slave_data_i = pixel;
            @(posedge clock_i);
            while (!slave_ready_o) begin
                @(posedge clock_i);
            end
            if (flag) begin
                expected_q.push_back(expected);
            end
            #1;
        end
        slave_valid_i = 1'b0;
    endtask

    task automatic run_pass(input string name, input bit stalls, input bit gaps);
        int errors_before;
        int outputs_before;
        errors_before = error_count;
        outputs_before = output_count;
        stall_mode = stalls;
        drive_pixels(gaps);
        while (expected_q.size() != 0) begin
            @(posedge clock_i);
        end
        #1;
        stall_mode = 1'b0;
        check_count(output_count - outputs_before, OUTPUTS_PER_PASS, "output count");
        if (error_count == errors_before) begin
            $display("Test %s: PASS", name);
            tests_passed++;
        end else begin
            $display("Test %s: FAIL", name);
            tests_failed++;
        end
    endtask

    initial begin
        int errors_before;
        reset_i = 1'b0;
        slave_valid_i = 1'b1;  // Pixels offered in reset must not be taken.
        slave_data_i = '0;
        master_ready_i = 1'b1;
        stall_mode = 1'b0;
        held_valid = 1'b0;
        held_data = '0;
        error_count = 0;
        output_count = 0;
        cycle_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        void'($urandom(76));
        $readmemh("sim/conv_patterns.hex", pattern_mem);

        errors_before = error_count;
        repeat (RESET_CYCLES) begin
            @(posedge clock_i);
            check_flag(master_valid_o, 1'b0, "master_valid_o in reset");
            check_flag(slave_ready_o, 1'b0, "slave_ready_o in reset");
        end
        #1;
        reset_i = 1'b1;
        slave_valid_i = 1'b0;
        repeat (3) begin
            @(posedge clock_i);
            check_flag(master_valid_o, 1'b0, "master_valid_o after reset");
        end
        #1;
        if (error_count == errors_before) begin
            $display("Test reset: PASS");
            tests_passed++;
        end else begin
            $display("Test reset: FAIL");
            tests_failed++;
        end

        run_pass("full_rate", 1'b0, 1'b0);
        run_pass("ready_stalls", 1'b1, 1'b0);
        run_pass("valid_gaps", 1'b0, 1'b1);
        run_pass("stalls_and_gaps", 1'b1, 1'b1);

        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : tb_horizontal_conv

// File: logic/horizontal_conv_top.sv
`timescale 1ns/1ps

`include "conv_params.svh"

module horizontal_conv_top
    import conv_types_pkg::*;
(
    input  bit         clock_i,
    input  bit         reset_i,

    input  bit         slave_valid_i,
    output bit         slave_ready_o,
    input  in_pixel_t  slave_data_i,

    output bit         master_valid_o,
    input  bit         master_ready_i,
    output out_pixel_t master_data_o
);

    window_t  window;
    bit       window_valid;
    sum_vec_t sums;

    assign slave_ready_o = reset_i && master_ready_i;  // Whole pipe stalls with the consumer.

    tap_window tap_window_inst (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .enable_i      (master_ready_i),
        .slave_valid_i (slave_valid_i),
        .pixel_i       (slave_data_i),
        .window_o      (window),
        .window_valid_o(window_valid)
    );

    for (genvar channel = 0; channel < `CONV_OUT_CHANNELS; channel++) begin : gen_channel
        channel_mac #(
            .OUT_CHANNEL(channel)
        ) channel_mac_inst (
            .clock_i (clock_i),
            .enable_i(master_ready_i),
            .window_i(window),
            .sum_o   (sums[channel])
        );
    end : gen_channel

    output_stage output_stage_inst (
        .clock_i       (clock_i),
        .reset_i       (reset_i),
        .enable_i      (master_ready_i),
        .window_valid_i(window_valid),
        .sums_i        (sums),
        .master_valid_o(master_valid_o),
        .master_data_o (master_data_o)
    );

endmodule : horizontal_conv_top

// File: logic/output_stage.sv
`timescale 1ns/1ps

`include "conv_params.svh"

module output_stage
    import conv_types_pkg::*;
    import conv_coeff_pkg::*;
(
    input  bit         clock_i,
    input  bit         reset_i,
    input  bit         enable_i,
    input  bit         window_valid_i,
    input  sum_vec_t   sums_i,
    output bit         master_valid_o,
    output out_pixel_t master_data_o
);

    // The tap flag already overlaps the first MAC stage, and the
    // last flag stage is the output valid register.
    localparam int FLAG_STAGES = `MAC_LATENCY - TAP_LATENCY + 1;

    bit [FLAG_STAGES-1:0] flag_pipe;

    function automatic activation_t post_process(sum_t value);
        sum_t shifted;
        activation_t cut;
        shifted = value >>> `RIGHT_SHIFT;
        cut = activation_t'(shifted[`ACT_WIDTH-1:0]);  // Upper bits are dropped.
        if (`USE_RELU != 0 && cut < 0) begin
            cut = '0;
        end
        return cut;
    endfunction : post_process

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            flag_pipe <= '0;
        end else if (enable_i) begin
            flag_pipe <= (flag_pipe << 1) | FLAG_STAGES'(window_valid_i);
        end
    end

    assign master_valid_o = flag_pipe[FLAG_STAGES-1];

    // Written on the same edge as the last flag stage.
    always_ff @(posedge clock_i) begin
        if (enable_i) begin
            for (int channel = 0; channel < `CONV_OUT_CHANNELS; channel++) begin
                master_data_o[channel] <= post_process(sum_t'(sums_i[channel]));
            end
        end
    end

    output_held : assert property (
        @(posedge clock_i) disable iff (!reset_i)
        master_valid_o && !enable_i |=> master_valid_o && $stable(master_data_o)
    ) else $error("output_stage: output changed while the consumer stalled");

endmodule : output_stage

// File: logic/channel_mac.sv
`timescale 1ns/1ps

`include "conv_params.svh"

module channel_mac
    import conv_types_pkg::*;
    import conv_coeff_pkg::*;
#(
    parameter int OUT_CHANNEL = 0
) (
    input  bit      clock_i,
    input  bit      enable_i,
    input  window_t window_i,
    output sum_t    sum_o
);

    localparam int TAP_TERMS = `CONV_IN_CHANNELS;
    localparam int TERMS = `KERNEL_WIDTH * TAP_TERMS;

    sum_t products [TERMS];
    sum_t tap_sums [`KERNEL_WIDTH];
    sum_t tree_sum;

    // First stage, one product per tap and input channel.
    always_ff @(posedge clock_i) begin
        if (enable_i) begin
            for (int tap = 0; tap < `KERNEL_WIDTH; tap++) begin
                for (int channel = 0; channel < `CONV_IN_CHANNELS; channel++) begin
                    products[tap * TAP_TERMS + channel] <=
                        sum_t'(activation_t'(window_i[tap][channel])) *
                        sum_t'(WEIGHTS[OUT_CHANNEL][channel][tap]);
                end
            end
        end
    end

    // Adder tree, per tap first, then across taps.
    always_comb begin
        for (int tap = 0; tap < `KERNEL_WIDTH; tap++) begin
            tap_sums[tap] = '0;
            for (int channel = 0; channel < `CONV_IN_CHANNELS; channel++) begin
                tap_sums[tap] = tap_sums[tap] + products[tap * TAP_TERMS + channel];
            end
        end
    end

    always_comb begin
        tree_sum = BIAS[OUT_CHANNEL];  // Bias rides in at the last level.
        for (int tap = 0; tap < `KERNEL_WIDTH; tap++) begin
            tree_sum = tree_sum + tap_sums[tap];
        end
    end

    // Second stage.
    always_ff @(posedge clock_i) begin
        if (enable_i) begin
            sum_o <= tree_sum;
        end
    end

endmodule : channel_mac

// File: logic/tap_window.sv
`timescale 1ns/1ps

`include "conv_params.svh"

module tap_window
    import conv_types_pkg::*;
(
    input  bit        clock_i,
    input  bit        reset_i,
    input  bit        enable_i,
    input  bit        slave_valid_i,
    input  in_pixel_t pixel_i,
    output window_t   window_o,
    output bit        window_valid_o
);

    localparam int COLUMN_WIDTH = $clog2(`ROW_WIDTH + 1);

    typedef bit [COLUMN_WIDTH-1:0] column_t;

    in_pixel_t [`KERNEL_WIDTH-2:0] history;  // Previous pixels with index 0 the oldest.
    column_t column;
    bit accept;

    assign accept = slave_valid_i && enable_i;

    // Newest pixel enters straight from the input, so the MAC samples
    // the full window on the accepting edge.
    assign window_o = {pixel_i, history};

    always_ff @(posedge clock_i) begin
        if (accept) begin
            history <= window_o[`KERNEL_WIDTH-1:1];  // Drop the oldest pixel.
        end
    end

    always_ff @(posedge clock_i) begin
        if (!reset_i) begin
            column <= '0;
            window_valid_o <= 1'b0;
        end else if (enable_i) begin
            window_valid_o <= accept && column >= column_t'(`KERNEL_WIDTH - 1);
            if (accept) begin
                if (column == column_t'(`ROW_WIDTH - 1)) begin
                    column <= '0;  // Next pixel starts a new row.
                end else begin
                    column <= column_t'(column + 1);
                end
            end
        end
    end

    column_in_row : assert property (
        @(posedge clock_i) disable iff (!reset_i)
        column <= column_t'(`ROW_WIDTH - 1)
    ) else $error("tap_window: column %0d is past the row end", column);

endmodule : tap_window

// File: logic/conv_coeff_pkg.sv
`include "conv_params.svh"

package conv_coeff_pkg;

    import conv_types_pkg::*;

    // Edges the window flag spends inside tap_window.
    localparam int TAP_LATENCY = 1;

    // Indexed [output channel][input channel][tap], tap 0 meets the oldest pixel.
    localparam weight_t WEIGHTS [`CONV_OUT_CHANNELS][`CONV_IN_CHANNELS][`KERNEL_WIDTH] = '{
        '{
            '{1, 2, 1},
            '{-1, 0, 1},
            '{3, -2, 4}
        },
        '{
            '{-4, 5, -6},
            '{7, -8, 9},
            '{2, 2, 2}
        }
    };

    localparam sum_t BIAS [`CONV_OUT_CHANNELS] = '{
        sum_t'(16),
        sum_t'(-40)
    };

endpackage : conv_coeff_pkg

// File: logic/conv_types_pkg.sv
`include "conv_params.svh"

package conv_types_pkg;

    // One signed activation as it travels on the streams.
    typedef bit signed [`ACT_WIDTH-1:0] activation_t;

    typedef bit signed [`WEIGHT_WIDTH-1:0] weight_t;

    // Wide enough for all products of one channel plus the bias.
    typedef bit signed [`SUM_WIDTH-1:0] sum_t;

    typedef activation_t [`CONV_IN_CHANNELS-1:0] in_pixel_t;

    typedef activation_t [`CONV_OUT_CHANNELS-1:0] out_pixel_t;

    typedef in_pixel_t [`KERNEL_WIDTH-1:0] window_t;  // Index 0 is the oldest pixel.

    typedef sum_t [`CONV_OUT_CHANNELS-1:0] sum_vec_t;  // One sum per output channel.

endpackage : conv_types_pkg

// File: include/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Pixel geometry.
`define CONV_IN_CHANNELS 3
`define CONV_OUT_CHANNELS 2
`define KERNEL_WIDTH 3
`define ROW_WIDTH 8

// Word sizes.
`define ACT_WIDTH 10
`define WEIGHT_WIDTH 8
`define SUM_WIDTH 24

// Output arithmetic.
`define RIGHT_SHIFT 2
`define USE_RELU 1

// Register stages inside one channel MAC.
`define MAC_LATENCY 2

`endif
